//--- div_pkg.sv
package div_pkg;

  // ====================================================================
  // Default widths
  // ====================================================================

  localparam int div_d_w_default    = 8;  // Divisor, quotient and remainder width.
  localparam int div_approx_default = 2;  // Low-order cells built as approximate.

  // ====================================================================
  // Result status
  // ====================================================================

  // Divide-by-zero wins over overflow when both apply.
  typedef enum logic [1:0] {
    st_ok       = 2'd0,  // Array result is valid.
    st_div_zero = 2'd1,  // Divisor is zero.
    st_overflow = 2'd2   // Upper dividend half at or above the divisor.
  } div_status_e;

  // ====================================================================
  // Result stage handshake state
  // ====================================================================

  typedef enum logic [1:0] {
    hs_idle = 2'd0,  // Waiting for a request.
    hs_busy = 2'd1,  // Operation in the array.
    hs_done = 2'd2   // Outputs valid, ack high.
  } hs_state_e;

endpackage

//--- div_decode.sv
`timescale 1ns/10ps

module div_decode #(
  parameter int d_w = 8
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req,
  input  logic                   ack,
  input  logic [2*d_w-1:0]       dividend,
  input  logic [d_w-1:0]         divisor,
  output logic                   start,
  output logic [2*d_w-1:0]       op_dividend,
  output logic [d_w-1:0]         op_divisor,
  output div_pkg::div_status_e   op_status
);

  logic                 req_q;      // Req from the previous edge.
  logic                 new_req;
  logic [d_w-1:0]       upper_half;
  div_pkg::div_status_e status_c;

  // ====================================================================
  // Request detection
  // ====================================================================

  // A new operation needs a rising req with the last ack already gone.
  assign new_req = req & ~req_q & ~ack;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_q <= 1'b0;
      start <= 1'b0;
    end else begin
      req_q <= req;
      start <= new_req;  // One-cycle pulse.
    end
  end

  // ====================================================================
  // Operand classification
  // ====================================================================

  assign upper_half = dividend[2*d_w-1:d_w];

  always_comb begin
    if (divisor == '0) begin
      status_c = div_pkg::st_div_zero;
    end else if (upper_half >= divisor) begin
      status_c = div_pkg::st_overflow;  // Quotient needs more than d_w bits.
    end else begin
      status_c = div_pkg::st_ok;
    end
  end

  // Operands and status stay put until the next request.
  always_ff @(posedge clk) begin
    if (new_req) begin
      op_dividend <= dividend;
      op_divisor  <= divisor;
      op_status   <= status_c;
    end
  end

endmodule

//--- div_array.sv
`timescale 1ns/10ps

module div_array #(
  parameter int d_w          = 8,
  parameter int approx_depth = 2
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start,
  input  logic [2*d_w-1:0] op_dividend,
  input  logic [d_w-1:0]   op_divisor,
  output logic             arr_valid,
  output logic [d_w-1:0]   arr_quotient,
  output logic [d_w-1:0]   arr_remainder
);

  // Row i produces quotient bit i; column j works on divisor bit j.
  logic [d_w-1:0] x_loc    [d_w];  // Minuend bit of each cell.
  logic [d_w-1:0] bin_loc  [d_w];  // Borrow into each cell.
  logic [d_w-1:0] b_loc    [d_w];  // Borrow out of each cell.
  logic [d_w-1:0] diff_loc [d_w];  // Difference before the quotient mux.
  logic [d_w-1:0] r_loc    [d_w];  // Partial remainder after the mux.
  logic [d_w-1:0] q_comb;

  // ====================================================================
  // Subtractor array
  // ====================================================================

  genvar i, j;
  generate
    for (i = 0; i < d_w; i++) begin : g_row
      for (j = 0; j < d_w; j++) begin : g_col

        // Column 0 always takes a fresh dividend bit; the top row takes
        // the upper dividend bits, the rest take the row above.
        if (j == 0) begin : g_x_new
          assign x_loc[i][j] = op_dividend[i];
        end else if (i == d_w - 1) begin : g_x_top
          assign x_loc[i][j] = op_dividend[d_w-1+j];
        end else begin : g_x_pass
          assign x_loc[i][j] = r_loc[i+1][j-1];
        end

        if (j == 0) begin : g_bin_zero
          assign bin_loc[i][j] = 1'b0;
        end else begin : g_bin_chain
          assign bin_loc[i][j] = b_loc[i][j-1];
        end

        if (i + j < approx_depth) begin : g_approx
          // Borrow-in is not used.
          assign b_loc[i][j]    = ~x_loc[i][j] & op_divisor[j];
          assign diff_loc[i][j] = x_loc[i][j] & ~op_divisor[j];
        end else begin : g_exact
          assign b_loc[i][j] = (~x_loc[i][j] & op_divisor[j]) |
                               (~(x_loc[i][j] ^ op_divisor[j]) & bin_loc[i][j]);
          assign diff_loc[i][j] = x_loc[i][j] ^ op_divisor[j] ^ bin_loc[i][j];
        end

        // Restore the minuend when the row's subtraction failed.
        assign r_loc[i][j] = q_comb[i] ? diff_loc[i][j] : x_loc[i][j];
      end

      if (i == d_w - 1) begin : g_q_top
        assign q_comb[i] = op_dividend[2*d_w-1] | ~b_loc[i][d_w-1];
      end else begin : g_q_row
        assign q_comb[i] = r_loc[i+1][d_w-1] | ~b_loc[i][d_w-1];
      end
    end
  endgenerate

  // ====================================================================
  // Output register
  // ====================================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      arr_valid <= 1'b0;
    end else begin
      arr_valid <= start;  // Result follows start by one cycle.
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      arr_quotient  <= q_comb;
      arr_remainder <= r_loc[0];  // Bottom row holds the remainder.
    end
  end

endmodule

//--- div_result.sv
`timescale 1ns/10ps

module div_result #(
  parameter int d_w = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req,
  input  logic                 arr_valid,
  input  logic [d_w-1:0]       arr_quotient,
  input  logic [d_w-1:0]       arr_remainder,
  input  div_pkg::div_status_e op_status,
  input  logic [d_w-1:0]       op_dividend_low,
  output logic                 ack,
  output logic [d_w-1:0]       quotient,
  output logic [d_w-1:0]       remainder,
  output div_pkg::div_status_e status
);

  div_pkg::hs_state_e state;
  logic [d_w-1:0]     q_sel;
  logic [d_w-1:0]     r_sel;

  // Special cases override the array.
  always_comb begin
    case (op_status)
      div_pkg::st_div_zero: begin
        q_sel = '1;
        r_sel = op_dividend_low;
      end
      div_pkg::st_overflow: begin
        q_sel = '1;
        r_sel = '1;
      end
      default: begin
        q_sel = arr_quotient;
        r_sel = arr_remainder;
      end
    endcase
  end

  // ====================================================================
  // Handshake FSM
  // ====================================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= div_pkg::hs_idle;
      ack       <= 1'b0;
      quotient  <= '0;
      remainder <= '0;
      status    <= div_pkg::st_ok;
    end else begin
      case (state)
        div_pkg::hs_idle: begin
          if (req) state <= div_pkg::hs_busy;
        end
        div_pkg::hs_busy: begin
          if (arr_valid) begin
            state     <= div_pkg::hs_done;
            ack       <= 1'b1;
            quotient  <= q_sel;
            remainder <= r_sel;
            status    <= op_status;
          end
        end
        div_pkg::hs_done: begin
          if (!req) begin  // Outputs hold until req drops.
            state <= div_pkg::hs_idle;
            ack   <= 1'b0;
          end
        end
        default: begin
          state <= div_pkg::hs_idle;
          ack   <= 1'b0;
        end
      endcase
    end
  end

endmodule

//--- approx_div_top.sv
`timescale 1ns/10ps

module approx_div_top #(
  parameter int d_w          = div_pkg::div_d_w_default,
  parameter int approx_depth = div_pkg::div_approx_default
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req,
  output logic                 ack,
  input  logic [2*d_w-1:0]     dividend,
  input  logic [d_w-1:0]       divisor,
  output logic [d_w-1:0]       quotient,
  output logic [d_w-1:0]       remainder,
  output div_pkg::div_status_e status
);

  logic                 start;
  logic [2*d_w-1:0]     op_dividend;
  logic [d_w-1:0]       op_divisor;
  div_pkg::div_status_e op_status;
  logic                 arr_valid;
  logic [d_w-1:0]       arr_quotient;
  logic [d_w-1:0]       arr_remainder;

  // ====================================================================
  // Decode, execute, result
  // ====================================================================

  div_decode #(
    .d_w (d_w)
  ) u_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .ack         (ack),
    .dividend    (dividend),
    .divisor     (divisor),
    .start       (start),
    .op_dividend (op_dividend),
    .op_divisor  (op_divisor),
    .op_status   (op_status)
  );

  div_array #(
    .d_w          (d_w),
    .approx_depth (approx_depth)
  ) u_array (
    .clk           (clk),
    .rst_n         (rst_n),
    .start         (start),
    .op_dividend   (op_dividend),
    .op_divisor    (op_divisor),
    .arr_valid     (arr_valid),
    .arr_quotient  (arr_quotient),
    .arr_remainder (arr_remainder)
  );

  div_result #(
    .d_w (d_w)
  ) u_result (
    .clk             (clk),
    .rst_n           (rst_n),
    .req             (req),
    .arr_valid       (arr_valid),
    .arr_quotient    (arr_quotient),
    .arr_remainder   (arr_remainder),
    .op_status       (op_status),
    .op_dividend_low (op_dividend[d_w-1:0]),  // Remainder on divide-by-zero.
    .ack             (ack),
    .quotient        (quotient),
    .remainder       (remainder),
    .status          (status)
  );

endmodule

//--- tb_approx_div.sv
`timescale 1ns/10ps

module tb_approx_div;

  localparam int d_w         = div_pkg::div_d_w_default;
  localparam int max_vectors = 64;
  localparam int ack_timeout = 20;  // Cycles allowed for any ack edge.

  logic                 clk;
  logic                 rst_n;
  logic                 req;
  logic                 ack;
  logic [2*d_w-1:0]     dividend;
  logic [d_w-1:0]       divisor;
  logic [d_w-1:0]       quotient;
  logic [d_w-1:0]       remainder;
  div_pkg::div_status_e status;

  // Dividend, divisor, quotient, remainder, status.
  logic [47:0] vec_mem [0:max_vectors-1];
  int          num_vectors;
  int          err_value;
  int          err_timeout;
  integer      seed;

  approx_div_top #(
    .d_w          (d_w),
    .approx_depth (div_pkg::div_approx_default)
  ) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .ack       (ack),
    .dividend  (dividend),
    .divisor   (divisor),
    .quotient  (quotient),
    .remainder (remainder),
    .status    (status)
  );

  always #2 clk = ~clk;

  // ====================================================================
  // Helpers
  // ====================================================================

  task automatic compare_field(input string name, input logic [15:0] exp_val,
                               input logic [15:0] got_val);
    if (exp_val !== got_val) begin
      $display("error at %0t ns: %s expected %h, got %h", $time, name, exp_val, got_val);
      err_value++;
    end
  endtask

  task automatic compare_outputs(input logic [47:0] v);
    logic [1:0] stat_val;
    stat_val = status;
    compare_field("quotient", {8'd0, v[23:16]}, {8'd0, quotient});
    compare_field("remainder", {8'd0, v[15:8]}, {8'd0, remainder});
    compare_field("status", {14'd0, v[1:0]}, {14'd0, stat_val});
  endtask

  task automatic run_vector(input int idx);
    logic [47:0] v;
    int          gap;
    int          hold;
    int          cycles;
    v    = vec_mem[idx];
    gap  = {$random(seed)} % 4;
    hold = {$random(seed)} % 3;
    repeat (gap) @(negedge clk);
    dividend = v[47:32];
    divisor  = v[31:24];
    req      = 1'b1;

    cycles = 0;
    while (ack !== 1'b1 && cycles < ack_timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (ack !== 1'b1) begin
      $display("timeout at %0t ns: ack never rose for vector %0d", $time, idx);
      err_timeout++;
    end else begin
      compare_field("ack rise latency", 16'd3, cycles[15:0]);
      compare_outputs(v);
    end

    // Outputs must stay frozen while req is held.
    repeat (hold) begin
      @(negedge clk);
      compare_field("ack", 16'd1, {15'd0, ack});
      compare_outputs(v);
    end

    req    = 1'b0;
    cycles = 0;
    while (ack !== 1'b0 && cycles < ack_timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (ack !== 1'b0) begin
      $display("timeout at %0t ns: ack never fell for vector %0d", $time, idx);
      err_timeout++;
    end else begin
      compare_field("ack fall latency", 16'd1, cycles[15:0]);
    end
  endtask

  // ====================================================================
  // Main sequence
  // ====================================================================

  initial begin
    logic [1:0] stat_val;
    clk         = 1'b0;
    rst_n       = 1'b0;
    req         = 1'b0;
    dividend    = '0;
    divisor     = '0;
    err_value   = 0;
    err_timeout = 0;
    seed        = 67;
    num_vectors = 0;

    // All ones marks an unused slot since status 8'hff never occurs.
    for (int k = 0; k < max_vectors; k++) begin
      vec_mem[k] = '1;
    end
    $readmemh("div_input.txt", vec_mem);
    for (int k = 0; k < max_vectors; k++) begin
      if (vec_mem[k] != '1) num_vectors = k + 1;
    end
    if (num_vectors == 0) begin
      $display("no vectors were read from div_input.txt");
      err_timeout++;
    end

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Reset state before the first request.
    @(negedge clk);
    stat_val = status;
    compare_field("ack", 16'd0, {15'd0, ack});
    compare_field("quotient", 16'd0, {8'd0, quotient});
    compare_field("remainder", 16'd0, {8'd0, remainder});
    compare_field("status", 16'd0, {14'd0, stat_val});

    for (int n = 0; n < num_vectors; n++) begin
      run_vector(n);
    end

    repeat (2) @(negedge clk);
    $display("vectors %0d, value errors %0d, timeout errors %0d",
             num_vectors, err_value, err_timeout);
    if (err_value == 0 && err_timeout == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- div_input.txt
// dividend_divisor_quotient_remainder_status, all hex
// status 00 ok, 01 divide by zero, 02 overflow
// Approximate cells change the result here
0002_01_03_00_00
0005_03_01_00_00
0004_01_05_00_00
0002_03_01_00_00
// Approximate cells give the exact answer here
0007_03_02_01_00
0006_03_02_00_00
0009_05_01_04_00
0001_01_01_00_00
0003_01_03_00_00
// Divisor low bits zero, so true division
1234_40_48_34_00
00FF_04_3F_03_00
7FFF_80_FF_7F_00
0000_10_00_00_00
ABCD_FC_AE_85_00
0064_0C_08_04_00
3039_44_B5_25_00
00C8_08_19_00_00
1000_20_80_00_00
0101_04_40_01_00
0F0F_10_F0_0F_00
2710_64_64_00_00
00FF_FC_01_03_00
// Divide by zero
1234_00_FF_34_01
00AB_00_FF_AB_01
0000_00_FF_00_01
// Quotient overflow
1234_12_FF_FF_02
FF00_01_FF_FF_02
0500_03_FF_FF_02
FFFF_FF_FF_FF_02
// Normal operands again after the special cases
0010_04_04_00_00
0005_03_01_00_00
1234_40_48_34_00

//--- sim.f
div_pkg.sv
div_decode.sv
div_array.sv
div_result.sv
approx_div_top.sv
tb_approx_div.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_approx_div
FILELIST  = sim.f

SRCS = $(shell grep '\.sv$$' $(FILELIST))
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
